// File: hw/combinerPkg.sv
// Shared widths, register map, combining modes and reset values for the combiner RTL and testbench
`default_nettype none

package combinerPkg;

    // **************************************************
    // Data path widths
    // **************************************************
    localparam int sampleWidth  = 16;
    localparam int levelWidth   = 16;
    localparam int dataWidth    = 32;
    localparam int addrWidth    = 6;
    localparam int lagWidth     = 4;
    localparam int optionsWidth = 16;

    // Largest level, also the saturated magnitude of the most negative sample
    localparam logic [levelWidth-1:0] levelMax = 16'h7fff;

    // Allowed range of the level filter shift
    localparam logic [lagWidth-1:0] lagMin = 4'd1;
    localparam logic [lagWidth-1:0] lagMax = 4'd8;

    // **************************************************
    // Register reset defaults
    // **************************************************
    localparam logic [lagWidth-1:0]     lagReset     = 4'd4;
    localparam logic [levelWidth-1:0]   swLmtReset   = 16'h0100;
    localparam logic [optionsWidth-1:0] optionsReset = 16'h0000;

    // **************************************************
    // Host word addresses
    // **************************************************
    typedef enum logic [addrWidth-1:0] {
        combLagCoef    = 6'd0,
        combSweepLimit = 6'd4,
        combOptions    = 6'd5,
        combAgcDiff    = 6'd8
    } regAddr;

    // Combining mode, held in options bits 1:0
    typedef enum logic [1:0] {
        // Master channel passes straight through
        modeSelect    = 2'd0,
        // Average of both channels
        modeEqualGain = 2'd1,
        // Output muted
        modeOff       = 2'd2
    } combMode;

endpackage

`default_nettype wire

// File: hw/channelLevel.sv
// Level detector for one receive channel: magnitude followed by a leaky integrator
`default_nettype none

module channelLevel (
    input  wire logic                                       busClk,
    input  wire logic                                       rstN,
    input  wire logic                                       sampleValid,
    input  wire logic signed [combinerPkg::sampleWidth-1:0] sample,
    input  wire logic        [combinerPkg::lagWidth-1:0]    lagShift,
    output logic             [combinerPkg::levelWidth-1:0]  level
);

    // Most negative sample code
    localparam logic signed [combinerPkg::sampleWidth-1:0] sampleMin =
        {1'b1, {(combinerPkg::sampleWidth-1){1'b0}}};

    logic        [combinerPkg::levelWidth-1:0] magnitude;
    logic signed [combinerPkg::levelWidth:0]   levelErr;
    logic signed [combinerPkg::levelWidth:0]   levelStep;
    logic signed [combinerPkg::levelWidth:0]   levelNext;

    // **************************************************
    // Magnitude with saturation
    // **************************************************
    always_comb begin
        if (sample == sampleMin) begin
            magnitude = combinerPkg::levelMax;
        end else if (sample[combinerPkg::sampleWidth-1]) begin
            magnitude = -sample;
        end else begin
            magnitude = sample;
        end
    end

    // **************************************************
    // Leaky integrator
    // **************************************************

    // One extra bit keeps the error signed
    assign levelErr  = $signed({1'b0, magnitude}) - $signed({1'b0, level});
    assign levelStep = levelErr >>> lagShift;

    // Step is at most half the error, so the sum stays in range
    assign levelNext = $signed({1'b0, level}) + levelStep;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            level <= '0;
        end else if (sampleValid) begin
            level <= levelNext[combinerPkg::levelWidth-1:0];
        end
    end

    assert property (@(posedge busClk) disable iff (!rstN) level <= combinerPkg::levelMax)
        else $error("channelLevel: level above 32767");

endmodule

`default_nettype wire

// File: hw/diversityCombine.sv
// Diversity decision block that forms the level differential, picks the master and combines samples
`default_nettype none

module diversityCombine (
    input  wire logic                                       busClk,
    input  wire logic                                       rstN,
    input  wire logic                                       sampleValid,
    input  wire logic signed [combinerPkg::sampleWidth-1:0] ch1Sample,
    input  wire logic signed [combinerPkg::sampleWidth-1:0] ch2Sample,
    input  wire logic        [combinerPkg::levelWidth-1:0]  level1,
    input  wire logic        [combinerPkg::levelWidth-1:0]  level2,
    input  wire logic        [combinerPkg::levelWidth-1:0]  swLmt,
    input  wire combinerPkg::combMode                       mode,
    output logic signed      [combinerPkg::sampleWidth-1:0] combinedSample,
    output logic                                            combinedValid,
    output logic             [combinerPkg::levelWidth-1:0]  agcDifferential,
    output logic                                            ch1IsMaster,
    output logic                                            combinerFlag
);

    // Two guard bits so the differences and the limit compare as signed
    localparam int cmpWidth = combinerPkg::levelWidth + 2;

    logic signed [cmpWidth-1:0]                   gap12;
    logic signed [cmpWidth-1:0]                   gap21;
    logic signed [cmpWidth-1:0]                   limit;
    logic signed [cmpWidth-1:0]                   absGap;
    logic                                         ch2Strong;
    logic                                         ch1Strong;
    logic                                         withinLmt;
    logic signed [combinerPkg::sampleWidth:0]     sampleSum;
    logic signed [combinerPkg::sampleWidth:0]     sampleHalf;
    logic signed [combinerPkg::sampleWidth-1:0]   combineNext;

    // **************************************************
    // Level comparison
    // **************************************************
    assign gap12 = $signed({2'b00, level1}) - $signed({2'b00, level2});
    assign gap21 = $signed({2'b00, level2}) - $signed({2'b00, level1});
    assign limit = $signed({2'b00, swLmt});

    assign absGap = gap12[cmpWidth-1] ? gap21 : gap12;

    // Hysteresis thresholds
    assign ch2Strong = gap21 > limit;
    assign ch1Strong = gap12 > limit;
    assign withinLmt = absGap <= limit;

    // **************************************************
    // Sample combining
    // **************************************************
    assign sampleSum  = ch1Sample + ch2Sample;
    assign sampleHalf = sampleSum >>> 1;

    // Master register still holds the choice made before this edge
    always_comb begin
        case (mode)
            combinerPkg::modeSelect: begin
                combineNext = ch1IsMaster ? ch1Sample : ch2Sample;
            end
            combinerPkg::modeEqualGain: begin
                combineNext = sampleHalf[combinerPkg::sampleWidth-1:0];
            end
            // Off and the unused code both mute
            default: begin
                combineNext = '0;
            end
        endcase
    end

    // **************************************************
    // Output registers
    // **************************************************
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            combinedValid   <= 1'b0;
            combinedSample  <= '0;
            agcDifferential <= '0;
            ch1IsMaster     <= 1'b1;
            combinerFlag    <= 1'b0;
        end else begin
            combinedValid <= sampleValid;
            if (sampleValid) begin
                combinedSample  <= combineNext;
                // Levels never exceed 32767, so the low half carries the sign
                agcDifferential <= gap12[combinerPkg::levelWidth-1:0];
                combinerFlag    <= withinLmt;
                if (ch2Strong) begin
                    ch1IsMaster <= 1'b0;
                end else if (ch1Strong) begin
                    ch1IsMaster <= 1'b1;
                end
            end
        end
    end

    // Switching the master needs a gap beyond the limit and so a clear flag
    assert property (@(posedge busClk) disable iff (!rstN)
        $changed(ch1IsMaster) |-> !combinerFlag)
        else $error("diversityCombine: master switched while combinerFlag is set");

endmodule

`default_nettype wire

// File: hw/combinerRegs.sv
// Host register file of the combiner with byte-lane writes and combinational status readback
`default_nettype none

module combinerRegs (
    input  wire logic                                  busClk,
    input  wire logic                                  rstN,
    input  wire logic [combinerPkg::addrWidth-1:0]     addr,
    input  wire logic [combinerPkg::dataWidth-1:0]     dataIn,
    input  wire logic                                  cs,
    input  wire logic                                  wr0,
    input  wire logic                                  wr1,
    input  wire logic                                  wr2,
    input  wire logic                                  wr3,
    input  wire logic                                  realLock,
    input  wire logic                                  imagLock,
    input  wire logic                                  ch1IsMaster,
    input  wire logic                                  combinerFlag,
    input  wire logic [combinerPkg::levelWidth-1:0]    agcDifferential,
    output logic      [combinerPkg::dataWidth-1:0]     dataOut,
    output logic      [combinerPkg::lagWidth-1:0]      lagShift,
    output logic      [combinerPkg::levelWidth-1:0]    swLmt,
    output combinerPkg::combMode                       mode
);

    // Stored fields
    logic [combinerPkg::lagWidth-1:0]     lag;
    logic [combinerPkg::optionsWidth-1:0] options;

    // Both carrier loops must be in lock
    logic locked;

    assign locked = realLock & imagLock;

    // **************************************************
    // Byte-lane writes
    // **************************************************
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            lag     <= combinerPkg::lagReset;
            swLmt   <= combinerPkg::swLmtReset;
            options <= combinerPkg::optionsReset;
        end else if (cs) begin
            // Lane 0
            if (wr0) begin
                case (addr)
                    combinerPkg::combLagCoef:    lag         <= dataIn[3:0];
                    combinerPkg::combSweepLimit: swLmt[7:0]  <= dataIn[7:0];
                    default: ;
                endcase
            end
            // Lane 1
            if (wr1) begin
                case (addr)
                    combinerPkg::combSweepLimit: swLmt[15:8] <= dataIn[15:8];
                    default: ;
                endcase
            end
            // Lanes 2 and 3 carry the options half-word
            if (wr2) begin
                case (addr)
                    combinerPkg::combOptions: options[7:0] <= dataIn[23:16];
                    default: ;
                endcase
            end
            if (wr3) begin
                case (addr)
                    combinerPkg::combOptions: options[15:8] <= dataIn[31:24];
                    default: ;
                endcase
            end
        end
    end

    // **************************************************
    // Control outputs
    // **************************************************

    // Stored lag reads back raw, the filter sees it clamped
    always_comb begin
        if (lag < combinerPkg::lagMin) begin
            lagShift = combinerPkg::lagMin;
        end else if (lag > combinerPkg::lagMax) begin
            lagShift = combinerPkg::lagMax;
        end else begin
            lagShift = lag;
        end
    end

    // Undefined code 3 is handled as off downstream
    assign mode = combinerPkg::combMode'(options[1:0]);

    // **************************************************
    // Readback
    // **************************************************
    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                combinerPkg::combLagCoef: begin
                    dataOut = {realLock, imagLock, locked, combinerFlag, ch1IsMaster,
                               23'd0, lag};
                end
                combinerPkg::combSweepLimit,
                combinerPkg::combOptions: begin
                    dataOut = {options, swLmt};
                end
                combinerPkg::combAgcDiff: begin
                    dataOut = {16'd0, agcDifferential};
                end
                default: begin
                    dataOut = '0;
                end
            endcase
        end
    end

    // Mode and options change only through a host write to their lanes
    assert property (@(posedge busClk) disable iff (!rstN)
        $changed(options) |-> $past(cs && (wr2 || wr3) && addr == combinerPkg::combOptions))
        else $error("combinerRegs: options changed without a host write");

endmodule

`default_nettype wire

// File: hw/combinerTop.sv
// Combiner subsystem top, two level detectors, the decision block and the host registers
`default_nettype none

module combinerTop (
    input  wire logic                                       busClk,
    input  wire logic                                       rstN,
    input  wire logic        [combinerPkg::addrWidth-1:0]   addr,
    input  wire logic        [combinerPkg::dataWidth-1:0]   dataIn,
    input  wire logic                                       cs,
    input  wire logic                                       wr0,
    input  wire logic                                       wr1,
    input  wire logic                                       wr2,
    input  wire logic                                       wr3,
    output logic             [combinerPkg::dataWidth-1:0]   dataOut,
    input  wire logic                                       sampleValid,
    input  wire logic signed [combinerPkg::sampleWidth-1:0] ch1Sample,
    input  wire logic signed [combinerPkg::sampleWidth-1:0] ch2Sample,
    input  wire logic                                       realLock,
    input  wire logic                                       imagLock,
    output logic signed      [combinerPkg::sampleWidth-1:0] combinedSample,
    output logic                                            combinedValid
);

    // Register controls
    logic [combinerPkg::lagWidth-1:0]   lagShift;
    logic [combinerPkg::levelWidth-1:0] swLmt;
    combinerPkg::combMode               mode;

    // Channel levels and decision status
    logic [combinerPkg::levelWidth-1:0] level1;
    logic [combinerPkg::levelWidth-1:0] level2;
    logic [combinerPkg::levelWidth-1:0] agcDifferential;
    logic                               ch1IsMaster;
    logic                               combinerFlag;

    // **************************************************
    // Level detectors
    // **************************************************
    channelLevel u_level1 (
        .busClk      (busClk),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sample      (ch1Sample),
        .lagShift    (lagShift),
        .level       (level1)
    );

    channelLevel u_level2 (
        .busClk      (busClk),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sample      (ch2Sample),
        .lagShift    (lagShift),
        .level       (level2)
    );

    // **************************************************
    // Decision and host access
    // **************************************************
    diversityCombine u_diversityCombine (
        .busClk          (busClk),
        .rstN            (rstN),
        .sampleValid     (sampleValid),
        .ch1Sample       (ch1Sample),
        .ch2Sample       (ch2Sample),
        .level1          (level1),
        .level2          (level2),
        .swLmt           (swLmt),
        .mode            (mode),
        .combinedSample  (combinedSample),
        .combinedValid   (combinedValid),
        .agcDifferential (agcDifferential),
        .ch1IsMaster     (ch1IsMaster),
        .combinerFlag    (combinerFlag)
    );

    combinerRegs u_combinerRegs (
        .busClk          (busClk),
        .rstN            (rstN),
        .addr            (addr),
        .dataIn          (dataIn),
        .cs              (cs),
        .wr0             (wr0),
        .wr1             (wr1),
        .wr2             (wr2),
        .wr3             (wr3),
        .realLock        (realLock),
        .imagLock        (imagLock),
        .ch1IsMaster     (ch1IsMaster),
        .combinerFlag    (combinerFlag),
        .agcDifferential (agcDifferential),
        .dataOut         (dataOut),
        .lagShift        (lagShift),
        .swLmt           (swLmt),
        .mode            (mode)
    );

endmodule

`default_nettype wire

// File: testbench/tbCombinerTop.sv
// Self-checking testbench for combinerTop that runs a register table and a sample table on a model
`default_nettype none

module tbCombinerTop;

    localparam int regRows       = 18;
    localparam int smpRows       = 20;
    localparam int fixedRows     = 11;
    localparam int timeoutCycles = (regRows + smpRows) * 20 + 200;

    // DUT connections
    logic                                       busClk = 1'b0;
    logic                                       rstN;
    logic        [combinerPkg::addrWidth-1:0]   addr;
    logic        [combinerPkg::dataWidth-1:0]   dataIn;
    logic                                       cs;
    logic                                       wr0;
    logic                                       wr1;
    logic                                       wr2;
    logic                                       wr3;
    logic        [combinerPkg::dataWidth-1:0]   dataOut;
    logic                                       sampleValid;
    logic signed [combinerPkg::sampleWidth-1:0] ch1Sample;
    logic signed [combinerPkg::sampleWidth-1:0] ch2Sample;
    logic                                       realLock;
    logic                                       imagLock;
    logic signed [combinerPkg::sampleWidth-1:0] combinedSample;
    logic                                       combinedValid;

    // Register table of address, cs on read, strobes, write data, locks and expected read
    logic [5:0]  regAddrTab [regRows];
    logic        regCsTab   [regRows];
    logic [3:0]  regStrbTab [regRows];
    logic [31:0] regDataTab [regRows];
    logic [1:0]  regLockTab [regRows];
    logic [31:0] regExpTab  [regRows];

    // Sample table of mode, switch limit and both channel samples
    combinerPkg::combMode smpModeTab [smpRows];
    logic [15:0]          smpLmtTab  [smpRows];
    logic signed [15:0]   smpCh1Tab  [smpRows];
    logic signed [15:0]   smpCh2Tab  [smpRows];

    // Reference model state
    logic [3:0] modelLag;
    int         modelLvl1;
    int         modelLvl2;
    int         modelDiff;
    logic       modelMaster;
    logic       modelFlag;

    int seed = 32'hc05c;
    int checks = 0;
    int errors = 0;

    combinerTop u_combinerTop (
        .busClk         (busClk),
        .rstN           (rstN),
        .addr           (addr),
        .dataIn         (dataIn),
        .cs             (cs),
        .wr0            (wr0),
        .wr1            (wr1),
        .wr2            (wr2),
        .wr3            (wr3),
        .dataOut        (dataOut),
        .sampleValid    (sampleValid),
        .ch1Sample      (ch1Sample),
        .ch2Sample      (ch2Sample),
        .realLock       (realLock),
        .imagLock       (imagLock),
        .combinedSample (combinedSample),
        .combinedValid  (combinedValid)
    );

    always #2 busClk = ~busClk;

    // **************************************************
    // Reference model
    // **************************************************
    function automatic int magOf(input logic signed [15:0] s);
        if (s == 16'h8000) begin
            return 32767;
        end else if (s < 0) begin
            return -int'(s);
        end
        return int'(s);
    endfunction

    function automatic int clampLag(input logic [3:0] lag);
        if (lag < 4'd1) begin
            return 1;
        end else if (lag > 4'd8) begin
            return 8;
        end
        return int'(lag);
    endfunction

    // Leaky integrator step toward the new magnitude
    function automatic int nextLevel(input int lvl, input int mag, input int shift);
        int err;
        err = mag - lvl;
        return lvl + (err >>> shift);
    endfunction

    function automatic logic [15:0] expectedSample(input combinerPkg::combMode m,
                                                   input logic signed [15:0] c1,
                                                   input logic signed [15:0] c2,
                                                   input logic master);
        int sum;
        sum = int'(c1) + int'(c2);
        case (m)
            combinerPkg::modeSelect:    return master ? c1 : c2;
            combinerPkg::modeEqualGain: return 16'(sum >>> 1);
            default:                    return 16'h0000;
        endcase
    endfunction

    // Decision uses the levels held before the sample
    function automatic void updateModel(input logic signed [15:0] c1,
                                        input logic signed [15:0] c2, input int lim);
        int gap;
        gap = modelLvl1 - modelLvl2;
        if (-gap > lim) begin
            modelMaster = 1'b0;
        end else if (gap > lim) begin
            modelMaster = 1'b1;
        end
        modelFlag = ((gap < 0) ? -gap : gap) <= lim;
        modelDiff = gap;
        modelLvl1 = nextLevel(modelLvl1, magOf(c1), clampLag(modelLag));
        modelLvl2 = nextLevel(modelLvl2, magOf(c2), clampLag(modelLag));
    endfunction

    // **************************************************
    // Table setup and checks
    // **************************************************
    task automatic addRegRow(input int i, input logic [5:0] a, input logic c,
                             input logic [3:0] s, input logic [31:0] d,
                             input logic [1:0] lk, input logic [31:0] e);
        regAddrTab[i] = a;
        regCsTab[i]   = c;
        regStrbTab[i] = s;
        regDataTab[i] = d;
        regLockTab[i] = lk;
        regExpTab[i]  = e;
    endtask

    task automatic addSampleRow(input int i, input combinerPkg::combMode m,
                                input logic [15:0] lim, input logic signed [15:0] c1,
                                input logic signed [15:0] c2);
        smpModeTab[i] = m;
        smpLmtTab[i]  = lim;
        smpCh1Tab[i]  = c1;
        smpCh2Tab[i]  = c2;
    endtask

    task automatic checkWord(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Write phase with cs high, then a read phase with the row's cs
    task automatic runRegRow(input int i);
        @(negedge busClk);
        addr = regAddrTab[i];
        dataIn = regDataTab[i];
        {realLock, imagLock} = regLockTab[i];
        cs = 1'b1;
        {wr3, wr2, wr1, wr0} = regStrbTab[i];
        if (regStrbTab[i][0] && regAddrTab[i] == combinerPkg::combLagCoef) begin
            modelLag = regDataTab[i][3:0];
        end
        @(negedge busClk);
        {wr3, wr2, wr1, wr0} = 4'b0000;
        cs = regCsTab[i];
        #1;
        checkWord($sformatf("register row %0d read", i), dataOut, regExpTab[i]);
    endtask

    // Host write of the filter shift between sample groups
    task automatic writeLag(input logic [3:0] lag);
        @(negedge busClk);
        cs = 1'b1;
        addr = combinerPkg::combLagCoef;
        dataIn = {28'd0, lag};
        wr0 = 1'b1;
        modelLag = lag;
        @(negedge busClk);
        wr0 = 1'b0;
        #1;
        checkWord("lag readback", {28'd0, dataOut[3:0]}, {28'd0, lag});
        cs = 1'b0;
    endtask

    task automatic runSampleRow(input int i);
        logic [15:0] expSample;
        @(negedge busClk);
        cs = 1'b1;
        addr = combinerPkg::combSweepLimit;
        dataIn = {16'h0000, smpLmtTab[i]};
        wr0 = 1'b1;
        wr1 = 1'b1;
        @(negedge busClk);
        addr = combinerPkg::combOptions;
        dataIn = {14'd0, smpModeTab[i], 16'h0000};
        wr0 = 1'b0;
        wr1 = 1'b0;
        wr2 = 1'b1;
        wr3 = 1'b1;
        @(negedge busClk);
        wr2 = 1'b0;
        wr3 = 1'b0;
        cs = 1'b0;
        sampleValid = 1'b1;
        ch1Sample = smpCh1Tab[i];
        ch2Sample = smpCh2Tab[i];
        expSample = expectedSample(smpModeTab[i], smpCh1Tab[i], smpCh2Tab[i], modelMaster);
        updateModel(smpCh1Tab[i], smpCh2Tab[i], int'(smpLmtTab[i]));
        // Result strobe one cycle after the valid
        @(negedge busClk);
        sampleValid = 1'b0;
        cs = 1'b1;
        addr = combinerPkg::combAgcDiff;
        #1;
        checkWord($sformatf("sample row %0d combinedValid", i), {31'd0, combinedValid}, 32'd1);
        checkWord($sformatf("sample row %0d combinedSample", i), {16'h0000, combinedSample},
                  {16'h0000, expSample});
        checkWord($sformatf("sample row %0d agcDiff read", i), dataOut,
                  {16'h0000, 16'(modelDiff)});
        @(negedge busClk);
        addr = combinerPkg::combLagCoef;
        #1;
        checkWord($sformatf("sample row %0d idle valid", i), {31'd0, combinedValid}, 32'd0);
        checkWord($sformatf("sample row %0d ch1IsMaster", i), {31'd0, dataOut[27]},
                  {31'd0, modelMaster});
        checkWord($sformatf("sample row %0d combinerFlag", i), {31'd0, dataOut[28]},
                  {31'd0, modelFlag});
    endtask

    // **************************************************
    // Watchdog
    // **************************************************
    initial begin
        repeat (timeoutCycles) @(posedge busClk);
        $display("Timeout: run did not complete within %0d cycles", timeoutCycles);
        $display("Verification failed");
        $finish;
    end

    // **************************************************
    // Main sequence
    // **************************************************
    initial begin
        logic [31:0] r;
        rstN = 1'b0;
        addr = '0;
        dataIn = '0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        sampleValid = 1'b0;
        ch1Sample = '0;
        ch2Sample = '0;
        realLock = 1'b0;
        imagLock = 1'b0;
        modelLag = combinerPkg::lagReset;
        modelLvl1 = 0;
        modelLvl2 = 0;
        modelDiff = 0;
        modelMaster = 1'b1;
        modelFlag = 1'b0;

        // Defaults, unmapped and deselected reads
        addRegRow(0, combinerPkg::combLagCoef, 1'b1, 4'b0000, 32'h0, 2'b00, 32'h0800_0004);
        addRegRow(1, combinerPkg::combSweepLimit, 1'b1, 4'b0000, 32'h0, 2'b00, 32'h0000_0100);
        addRegRow(2, combinerPkg::combOptions, 1'b1, 4'b0000, 32'h0, 2'b00, 32'h0000_0100);
        addRegRow(3, combinerPkg::combAgcDiff, 1'b1, 4'b0000, 32'h0, 2'b00, 32'h0);
        addRegRow(4, 6'd2, 1'b1, 4'b0000, 32'h0, 2'b00, 32'h0);
        addRegRow(5, combinerPkg::combLagCoef, 1'b0, 4'b0000, 32'h0, 2'b00, 32'h0);
        // Byte lanes
        addRegRow(6, combinerPkg::combSweepLimit, 1'b1, 4'b0001, 32'hffff_ff40, 2'b00,
                  32'h0000_0140);
        addRegRow(7, combinerPkg::combSweepLimit, 1'b1, 4'b0010, 32'haaaa_02bb, 2'b00,
                  32'h0000_0240);
        addRegRow(8, combinerPkg::combOptions, 1'b1, 4'b1100, 32'h0001_ffff, 2'b00,
                  32'h0001_0240);
        addRegRow(9, combinerPkg::combOptions, 1'b1, 4'b0100, 32'hab02_0000, 2'b00,
                  32'h0002_0240);
        addRegRow(10, combinerPkg::combOptions, 1'b1, 4'b1000, 32'h3300_0000, 2'b00,
                  32'h3302_0240);
        addRegRow(11, combinerPkg::combOptions, 1'b1, 4'b0011, 32'h0000_ffff, 2'b00,
                  32'h3302_0240);
        // Lag stored raw and locks in the top bits
        addRegRow(12, combinerPkg::combLagCoef, 1'b1, 4'b0001, 32'h0, 2'b00, 32'h0800_0000);
        addRegRow(13, combinerPkg::combLagCoef, 1'b1, 4'b1111, 32'hffff_ffff, 2'b00,
                  32'h0800_000f);
        addRegRow(14, combinerPkg::combLagCoef, 1'b1, 4'b0000, 32'h0, 2'b10, 32'h8800_000f);
        addRegRow(15, combinerPkg::combLagCoef, 1'b1, 4'b0000, 32'h0, 2'b11, 32'he800_000f);
        addRegRow(16, combinerPkg::combLagCoef, 1'b1, 4'b0000, 32'h0, 2'b01, 32'h4800_000f);
        addRegRow(17, combinerPkg::combLagCoef, 1'b1, 4'b0001, 32'h0, 2'b00, 32'h0800_0000);

        // Strong channel 2, then held master, then the other modes
        addSampleRow(0, combinerPkg::modeSelect, 16'h0100, 16'sd100, 16'sd3000);
        addSampleRow(1, combinerPkg::modeSelect, 16'h0100, 16'sd100, 16'sd3000);
        addSampleRow(2, combinerPkg::modeSelect, 16'h0100, 16'sd100, 16'sd3000);
        addSampleRow(3, combinerPkg::modeSelect, 16'h4000, 16'sd20000, -16'sd5);
        addSampleRow(4, combinerPkg::modeSelect, 16'h4000, 16'sd20000, -16'sd5);
        addSampleRow(5, combinerPkg::modeSelect, 16'h0010, 16'sd20000, 16'sh8000);
        addSampleRow(6, combinerPkg::modeEqualGain, 16'h0100, 16'sd1001, 16'sd3000);
        addSampleRow(7, combinerPkg::modeEqualGain, 16'h0100, 16'sh8000, 16'sh8000);
        addSampleRow(8, combinerPkg::modeEqualGain, 16'h0100, 16'sd32767, 16'sd1);
        addSampleRow(9, combinerPkg::modeOff, 16'h0100, 16'sd1234, -16'sd1234);
        addSampleRow(10, combinerPkg::modeEqualGain, 16'h0100, -16'sd3, 16'sd0);
        for (int i = fixedRows; i < smpRows; i++) begin
            r = $random(seed);
            smpModeTab[i] = (r[1:0] == 2'd3) ? combinerPkg::modeSelect
                                             : combinerPkg::combMode'(r[1:0]);
            smpLmtTab[i] = {6'd0, r[11:2]};
            r = $random(seed);
            smpCh1Tab[i] = r[15:0];
            smpCh2Tab[i] = r[31:16];
        end

        repeat (4) @(negedge busClk);
        rstN = 1'b1;

        for (int i = 0; i < regRows; i++) begin
            runRegRow(i);
        end
        for (int i = 0; i < fixedRows; i++) begin
            runSampleRow(i);
        end
        // Random rows run with the largest stored shift, which the filter clamps
        writeLag(4'hf);
        for (int i = fixedRows; i < smpRows; i++) begin
            runSampleRow(i);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/combinerPkg.sv
hw/channelLevel.sv
hw/diversityCombine.sv
hw/combinerRegs.sv
hw/combinerTop.sv
testbench/tbCombinerTop.sv

// File: Makefile
TOP = tbCombinerTop
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
